/* verilog/life_defs.svh */
// grid geometry, bank layout and APB register map, included by the packages and the RTL
`ifndef LIFE_DEFS_SVH
`define LIFE_DEFS_SVH

// visible grid size
`define LIFE_ROWS 12
`define LIFE_COLS 12

// stored rows carry one dead border bit on each side
`define LIFE_BANK_WIDTH (`LIFE_COLS + 2)
`define LIFE_BANKS 3
`define LIFE_BANK_DEPTH ((`LIFE_ROWS + `LIFE_BANKS - 1) / `LIFE_BANKS)

`define LIFE_ROW_BITS 4
`define LIFE_COL_BITS 4

// register offsets on the APB
`define LIFE_APB_ADDR_BITS 4
`define LIFE_REG_CTRL 4'h0
`define LIFE_REG_CELL 4'h4
`define LIFE_REG_ROW 4'h8

`endif

/* verilog/life_mem_pkg.sv */
// row memory command codes and the stored row type, shared by memory, sequencer and registers
package life_mem_pkg;

`include "life_defs.svh"

    // commands on the sequencer to memory port
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_LD,
        MEM_WR_ROW,
        MEM_ST_CELL
    } mem_cmd_t;

    // bit 0 and the top bit are the dead border
    typedef logic [`LIFE_BANK_WIDTH-1:0] row_vec_t;

endpackage

/* verilog/life_regs_pkg.sv */
// register slot names and the two decodes of one APB write word
package life_regs_pkg;

`include "life_defs.svh"

    // decoded paddr
    typedef enum logic [1:0] {
        SEL_CTRL,
        SEL_CELL,
        SEL_ROW,
        SEL_NONE
    } reg_sel_t;

    // ctrl_word at CTRL, cell_word at CELL and ROW
    typedef union packed {
        struct packed {
            logic [15:0] rsvd_hi;
            logic [7:0]  gens;
            logic [5:0]  rsvd_lo;
            logic        clear;
            logic        start;
        } ctrl_word;
        struct packed {
            logic [15-`LIFE_ROW_BITS:0] rsvd_hi;
            logic [`LIFE_ROW_BITS-1:0]  row;
            logic [7-`LIFE_COL_BITS:0]  rsvd_mid;
            logic [`LIFE_COL_BITS-1:0]  col;
            logic [6:0]                 rsvd_lo;
            logic                       value;
        } cell_word;
    } apb_word_u;

endpackage

/* verilog/row_bank_mem.sv */
// three-bank row memory with dirty list, serving neighbourhood loads, row stores and cell writes
`timescale 1ns/1ps
`include "life_defs.svh"

module row_bank_mem (
    input  logic                         clock,
    input  logic                         reset,
    input  life_mem_pkg::mem_cmd_t       mem_cmd,
    input  logic [`LIFE_ROW_BITS-1:0]    mem_row,
    input  logic [`LIFE_COL_BITS-1:0]    mem_col,
    input  logic                         mem_bit,
    input  life_mem_pkg::row_vec_t       mem_wdata,
    input  logic                         mem_clear,
    output logic                         mem_ready,
    output logic                         mem_done,
    output life_mem_pkg::row_vec_t       rows_above,
    output life_mem_pkg::row_vec_t       rows_mid,
    output life_mem_pkg::row_vec_t       rows_below
);

    localparam int LINE_BITS = $clog2(`LIFE_BANK_DEPTH);

    life_mem_pkg::row_vec_t   bank_mem [`LIFE_BANKS][`LIFE_BANK_DEPTH];
    life_mem_pkg::row_vec_t   bank_q [`LIFE_BANKS];
    logic [`LIFE_ROWS-1:0]    dirty;
    logic [LINE_BITS-1:0]     line_addr [`LIFE_BANKS];
    logic [1:0]               mod_in;
    logic [LINE_BITS-1:0]     quo_in;
    logic                     accept;

    // stage 1 state, one cycle after acceptance
    logic                     s1_valid;
    life_mem_pkg::mem_cmd_t   s1_cmd;
    logic [`LIFE_ROW_BITS-1:0] row_q;
    logic [`LIFE_COL_BITS-1:0] col_q;
    logic                     bit_q;
    life_mem_pkg::row_vec_t   wdata_q;
    logic [1:0]               mod_q;
    logic [LINE_BITS-1:0]     quo_q;
    logic                     above_ok;
    logic                     mid_ok;
    logic                     below_ok;
    life_mem_pkg::row_vec_t   cell_row;

    // busy for the two cycles up to and including done
    assign mem_ready = !s1_valid && !mem_done;
    assign accept    = mem_ready && (mem_cmd != life_mem_pkg::MEM_IDLE);

    assign mod_in = 2'(mem_row % 3);
    assign quo_in = LINE_BITS'(mem_row / 3);
    assign mod_q  = 2'(row_q % 3);
    assign quo_q  = LINE_BITS'(row_q / 3);

    // each bank serves whichever of r-1, r, r+1 falls into it
    always_comb begin
        for (int b = 0; b < `LIFE_BANKS; b++) begin
            if (b == int'(mod_in))
                line_addr[b] = quo_in;
            else if (b == (int'(mod_in) + 1) % 3)
                line_addr[b] = quo_in + LINE_BITS'(mod_in == 2'd2);
            else
                line_addr[b] = quo_in - LINE_BITS'(mod_in == 2'd0);
        end
    end

    // rows outside the grid or never written read as dead
    assign above_ok = (row_q != '0) ? dirty[row_q - 1'b1] : 1'b0;
    assign mid_ok   = (row_q < `LIFE_ROWS) ? dirty[row_q] : 1'b0;
    assign below_ok = (row_q < `LIFE_ROWS - 1) ? dirty[row_q + 1'b1] : 1'b0;

    // cell read-modify-write, column offset by the left border bit
    always_comb begin
        cell_row = mid_ok ? bank_q[mod_q] : '0;
        if (col_q < `LIFE_COLS)
            cell_row[col_q + 1'b1] = bit_q;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
            mem_done <= 1'b0;
            dirty    <= '0;
        end else begin
            s1_valid <= accept;
            mem_done <= s1_valid;
            if (mem_clear)
                dirty <= '0;
            else if (s1_valid && row_q < `LIFE_ROWS &&
                     (s1_cmd == life_mem_pkg::MEM_WR_ROW || s1_cmd == life_mem_pkg::MEM_ST_CELL))
                dirty[row_q] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            s1_cmd  <= mem_cmd;
            row_q   <= mem_row;
            col_q   <= mem_col;
            bit_q   <= mem_bit;
            wdata_q <= mem_wdata;
            for (int b = 0; b < `LIFE_BANKS; b++)
                bank_q[b] <= bank_mem[b][line_addr[b]];
        end
        if (s1_valid && row_q < `LIFE_ROWS) begin
            if (s1_cmd == life_mem_pkg::MEM_WR_ROW)
                bank_mem[mod_q][quo_q] <= wdata_q;
            else if (s1_cmd == life_mem_pkg::MEM_ST_CELL)
                bank_mem[mod_q][quo_q] <= cell_row;
        end
        // rotate bank outputs into above, middle, below order
        if (s1_valid && s1_cmd == life_mem_pkg::MEM_LD) begin
            rows_above <= above_ok ? bank_q[(mod_q + 2) % 3] : '0;
            rows_mid   <= mid_ok ? bank_q[mod_q] : '0;
            rows_below <= below_ok ? bank_q[(mod_q + 1) % 3] : '0;
        end
    end

    // a load lands two cycles after it is taken, with dead borders on all three rows
    assert property (@(posedge clock) disable iff (reset)
        (accept && mem_cmd == life_mem_pkg::MEM_LD) |-> ##2
            (mem_done &&
             !(rows_above[0] || rows_mid[0] || rows_below[0]) &&
             !(rows_above[`LIFE_BANK_WIDTH-1] || rows_mid[`LIFE_BANK_WIDTH-1] ||
               rows_below[`LIFE_BANK_WIDTH-1])));

    // rows stored by the sequencer keep a dead border
    assert property (@(posedge clock) disable iff (reset)
        (accept && mem_cmd == life_mem_pkg::MEM_WR_ROW) |->
            (mem_wdata[0] == 1'b0 && mem_wdata[`LIFE_BANK_WIDTH-1] == 1'b0));

endmodule

/* verilog/life_row_step.sv */
// next-generation rule for one row from its three-row neighbourhood, result registered
`timescale 1ns/1ps
`include "life_defs.svh"

module life_row_step (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    step_go,
    input  life_mem_pkg::row_vec_t  rows_above,
    input  life_mem_pkg::row_vec_t  rows_mid,
    input  life_mem_pkg::row_vec_t  rows_below,
    output life_mem_pkg::row_vec_t  step_row,
    output logic                    step_valid
);

    life_mem_pkg::row_vec_t next_row;

    // border bits stay zero, only inner columns are computed
    always_comb begin
        logic [3:0] count;
        next_row = '0;
        for (int c = 1; c <= `LIFE_COLS; c++) begin
            count = rows_above[c-1] + rows_above[c] + rows_above[c+1]
                  + rows_mid[c-1] + rows_mid[c+1]
                  + rows_below[c-1] + rows_below[c] + rows_below[c+1];
            // birth on three, survival on two or three
            next_row[c] = (count == 4'd3) || (count == 4'd2 && rows_mid[c]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            step_valid <= 1'b0;
        else
            step_valid <= step_go;
    end

    // result holds until the next step so it can wait for write-back
    always_ff @(posedge clock) begin
        if (step_go)
            step_row <= next_row;
    end

endmodule

/* verilog/life_sequencer.sv */
// generation stepper that owns the memory port and forwards host requests while idle
`timescale 1ns/1ps
`include "life_defs.svh"

module life_sequencer (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         run_start,
    input  logic [7:0]                   run_gens,
    input  logic                         clear_grid,
    input  life_mem_pkg::mem_cmd_t       host_cmd,
    input  logic [`LIFE_ROW_BITS-1:0]    host_row,
    input  logic [`LIFE_COL_BITS-1:0]    host_col,
    input  logic                         host_bit,
    input  logic                         mem_ready,
    input  logic                         mem_done,
    input  life_mem_pkg::row_vec_t       rows_above,
    input  life_mem_pkg::row_vec_t       rows_mid,
    input  life_mem_pkg::row_vec_t       rows_below,
    input  life_mem_pkg::row_vec_t       step_row,
    input  logic                         step_valid,
    output logic                         busy,
    output logic [7:0]                   gen_total,
    output logic                         host_done,
    output logic                         host_err,
    output life_mem_pkg::row_vec_t       host_rows,
    output life_mem_pkg::mem_cmd_t       mem_cmd,
    output logic [`LIFE_ROW_BITS-1:0]    mem_row,
    output logic [`LIFE_COL_BITS-1:0]    mem_col,
    output logic                         mem_bit,
    output life_mem_pkg::row_vec_t       mem_wdata,
    output logic                         mem_clear,
    output logic                         step_go
);

    localparam logic [3:0] S_IDLE       = 4'd0;
    localparam logic [3:0] S_HOST       = 4'd1;
    localparam logic [3:0] S_LOAD       = 4'd2;
    localparam logic [3:0] S_LOAD_WAIT  = 4'd3;
    localparam logic [3:0] S_STEP       = 4'd4;
    localparam logic [3:0] S_WB         = 4'd5;
    localparam logic [3:0] S_WB_WAIT    = 4'd6;
    localparam logic [3:0] S_FLUSH      = 4'd7;
    localparam logic [3:0] S_FLUSH_WAIT = 4'd8;
    localparam logic [`LIFE_ROW_BITS-1:0] LAST_ROW = `LIFE_ROW_BITS'(`LIFE_ROWS - 1);

    logic [3:0]                state;
    logic [`LIFE_ROW_BITS-1:0] row_q;
    logic [`LIFE_ROW_BITS-1:0] loaded_q;
    logic [7:0]                gens_left;
    logic                      have_held;
    life_mem_pkg::row_vec_t    held_q;
    logic                      run_go;
    logic                      wb_finish;

    assign run_go    = run_start && (run_gens != 8'd0);
    assign busy      = (state != S_IDLE) && (state != S_HOST);
    assign host_done = (state == S_HOST) && mem_done;
    // a run refuses host traffic outright
    assign host_err  = busy && (host_cmd != life_mem_pkg::MEM_IDLE);
    assign host_rows = rows_mid;
    // load outputs feed the step unit directly in the done cycle
    assign step_go   = (state == S_LOAD_WAIT) && mem_done;
    assign mem_clear = clear_grid && !busy;

    // the held row is written, or taken as the first held row, before moving on
    assign wb_finish = ((state == S_WB) && !have_held) || ((state == S_WB_WAIT) && mem_done);

    always_comb begin
        mem_cmd   = life_mem_pkg::MEM_IDLE;
        mem_row   = row_q;
        mem_col   = '0;
        mem_bit   = 1'b0;
        mem_wdata = held_q;
        case (state)
            S_IDLE: begin
                if (!run_go) begin
                    mem_cmd = host_cmd;
                    mem_row = host_row;
                    mem_col = host_col;
                    mem_bit = host_bit;
                end
            end
            S_LOAD:  mem_cmd = life_mem_pkg::MEM_LD;
            // held row is r-1, safe once the load of r is done
            S_WB: begin
                if (have_held) begin
                    mem_cmd = life_mem_pkg::MEM_WR_ROW;
                    mem_row = row_q - 1'b1;
                end
            end
            S_FLUSH: mem_cmd = life_mem_pkg::MEM_WR_ROW;
            default: mem_cmd = life_mem_pkg::MEM_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= S_IDLE;
            row_q     <= '0;
            loaded_q  <= '0;
            gens_left <= '0;
            have_held <= 1'b0;
            gen_total <= '0;
        end else begin
            if (mem_clear)
                gen_total <= '0;
            case (state)
                S_IDLE: begin
                    if (run_go) begin
                        gens_left <= run_gens;
                        row_q     <= '0;
                        loaded_q  <= '0;
                        have_held <= 1'b0;
                        state     <= S_LOAD;
                    end else if (host_cmd != life_mem_pkg::MEM_IDLE && mem_ready) begin
                        state <= S_HOST;
                    end
                end
                S_HOST:      if (mem_done) state <= S_IDLE;
                S_LOAD:      if (mem_ready) state <= S_LOAD_WAIT;
                S_LOAD_WAIT: begin
                    if (mem_done) begin
                        loaded_q <= row_q;
                        state    <= S_STEP;
                    end
                end
                S_STEP:      if (step_valid) state <= S_WB;
                S_WB:        if (have_held && mem_ready) state <= S_WB_WAIT;
                // wb_finish below moves on once the write is done
                S_WB_WAIT:   state <= S_WB_WAIT;
                S_FLUSH:     if (mem_ready) state <= S_FLUSH_WAIT;
                S_FLUSH_WAIT: begin
                    // generation complete, last row is in memory
                    if (mem_done) begin
                        gen_total <= gen_total + 8'd1;
                        gens_left <= gens_left - 8'd1;
                        have_held <= 1'b0;
                        row_q     <= '0;
                        loaded_q  <= '0;
                        state     <= (gens_left == 8'd1) ? S_IDLE : S_LOAD;
                    end
                end
                default:     state <= S_IDLE;
            endcase
            if (wb_finish) begin
                have_held <= 1'b1;
                if (row_q == LAST_ROW) begin
                    state <= S_FLUSH;
                end else begin
                    row_q <= row_q + 1'b1;
                    state <= S_LOAD;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wb_finish)
            held_q <= step_row;
    end

    // a row is only rewritten once every neighbourhood that reads it has loaded
    assert property (@(posedge clock) disable iff (reset)
        (busy && mem_ready && mem_cmd == life_mem_pkg::MEM_WR_ROW) |->
            (mem_row < loaded_q || (mem_row == LAST_ROW && loaded_q == LAST_ROW)));

endmodule

/* verilog/life_apb_regs.sv */
// APB slave for control, status, cell writes and row reads, steering the sequencer
`timescale 1ns/1ps
`include "life_defs.svh"

module life_apb_regs (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [`LIFE_APB_ADDR_BITS-1:0]   paddr,
    input  logic [31:0]                      pwdata,
    input  logic                             busy,
    input  logic [7:0]                       gen_total,
    input  logic                             host_done,
    input  logic                             host_err,
    input  life_mem_pkg::row_vec_t           host_rows,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic                             run_start,
    output logic [7:0]                       run_gens,
    output logic                             clear_grid,
    output life_mem_pkg::mem_cmd_t           host_cmd,
    output logic [`LIFE_ROW_BITS-1:0]        host_row,
    output logic [`LIFE_COL_BITS-1:0]        host_col,
    output logic                             host_bit
);

    life_regs_pkg::reg_sel_t  sel;
    life_regs_pkg::apb_word_u word;
    logic                     setup;
    logic                     access;
    logic                     host_access;
    logic                     ctrl_write;

    assign word   = pwdata;
    assign setup  = psel && !penable;
    assign access = psel && penable;

    always_comb begin
        case (paddr)
            `LIFE_REG_CTRL: sel = life_regs_pkg::SEL_CTRL;
            `LIFE_REG_CELL: sel = life_regs_pkg::SEL_CELL;
            `LIFE_REG_ROW:  sel = life_regs_pkg::SEL_ROW;
            default:        sel = life_regs_pkg::SEL_NONE;
        endcase
    end

    // cell writes and row reads go through the memory and wait for it
    assign host_access = (sel == life_regs_pkg::SEL_CELL && pwrite) ||
                         (sel == life_regs_pkg::SEL_ROW && !pwrite);
    assign ctrl_write  = access && pwrite && (sel == life_regs_pkg::SEL_CTRL);

    assign pready  = access && (!host_access || host_done || host_err);
    assign pslverr = access && ((sel == life_regs_pkg::SEL_NONE) || (host_access && host_err));

    // control pulses last the single zero-wait access cycle
    assign run_start  = ctrl_write && word.ctrl_word.start;
    assign clear_grid = ctrl_write && word.ctrl_word.clear;
    assign run_gens   = word.ctrl_word.gens;

    always_comb begin
        prdata = '0;
        if (sel == life_regs_pkg::SEL_CTRL) begin
            prdata[0]    = busy;
            prdata[15:8] = gen_total;
        end else if (sel == life_regs_pkg::SEL_ROW) begin
            // drop the border bits
            prdata[`LIFE_COLS-1:0] = host_rows[`LIFE_COLS:1];
        end
    end

    // request raised in setup, held until the sequencer answers
    always_ff @(posedge clock) begin
        if (reset)
            host_cmd <= life_mem_pkg::MEM_IDLE;
        else if (host_done || host_err)
            host_cmd <= life_mem_pkg::MEM_IDLE;
        else if (setup && host_access)
            host_cmd <= (sel == life_regs_pkg::SEL_CELL) ? life_mem_pkg::MEM_ST_CELL
                                                         : life_mem_pkg::MEM_LD;
    end

    always_ff @(posedge clock) begin
        if (setup && host_access) begin
            host_row <= word.cell_word.row;
            host_col <= word.cell_word.col;
            host_bit <= word.cell_word.value;
        end
    end

    // slave errors end the transfer and a refused host access had its request raised
    assert property (@(posedge clock) disable iff (reset)
        pslverr |-> (pready && (sel == life_regs_pkg::SEL_NONE ||
                                host_cmd != life_mem_pkg::MEM_IDLE)));

endmodule

/* verilog/life_top.sv */
// Life engine top level with an APB3 slave port, joining registers, sequencer, step unit and memory
`timescale 1ns/1ps
`include "life_defs.svh"

module life_top (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`LIFE_APB_ADDR_BITS-1:0]  paddr,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr
);

    // register block to sequencer
    logic                       run_start;
    logic [7:0]                 run_gens;
    logic                       clear_grid;
    life_mem_pkg::mem_cmd_t     host_cmd;
    logic [`LIFE_ROW_BITS-1:0]  host_row;
    logic [`LIFE_COL_BITS-1:0]  host_col;
    logic                       host_bit;
    logic                       busy;
    logic [7:0]                 gen_total;
    logic                       host_done;
    logic                       host_err;
    life_mem_pkg::row_vec_t     host_rows;

    // sequencer to memory
    life_mem_pkg::mem_cmd_t     mem_cmd;
    logic [`LIFE_ROW_BITS-1:0]  mem_row;
    logic [`LIFE_COL_BITS-1:0]  mem_col;
    logic                       mem_bit;
    life_mem_pkg::row_vec_t     mem_wdata;
    logic                       mem_clear;
    logic                       mem_ready;
    logic                       mem_done;
    life_mem_pkg::row_vec_t     rows_above;
    life_mem_pkg::row_vec_t     rows_mid;
    life_mem_pkg::row_vec_t     rows_below;

    // step unit
    logic                       step_go;
    life_mem_pkg::row_vec_t     step_row;
    logic                       step_valid;

    life_apb_regs u_regs (
        .clock(clock), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .busy(busy), .gen_total(gen_total), .host_done(host_done), .host_err(host_err),
        .host_rows(host_rows), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .run_start(run_start), .run_gens(run_gens), .clear_grid(clear_grid),
        .host_cmd(host_cmd), .host_row(host_row), .host_col(host_col), .host_bit(host_bit)
    );

    life_sequencer u_seq (
        .clock(clock), .reset(reset),
        .run_start(run_start), .run_gens(run_gens), .clear_grid(clear_grid),
        .host_cmd(host_cmd), .host_row(host_row), .host_col(host_col), .host_bit(host_bit),
        .mem_ready(mem_ready), .mem_done(mem_done),
        .rows_above(rows_above), .rows_mid(rows_mid), .rows_below(rows_below),
        .step_row(step_row), .step_valid(step_valid),
        .busy(busy), .gen_total(gen_total), .host_done(host_done), .host_err(host_err),
        .host_rows(host_rows), .mem_cmd(mem_cmd), .mem_row(mem_row), .mem_col(mem_col),
        .mem_bit(mem_bit), .mem_wdata(mem_wdata), .mem_clear(mem_clear), .step_go(step_go)
    );

    life_row_step u_step (
        .clock(clock), .reset(reset), .step_go(step_go),
        .rows_above(rows_above), .rows_mid(rows_mid), .rows_below(rows_below),
        .step_row(step_row), .step_valid(step_valid)
    );

    row_bank_mem u_mem (
        .clock(clock), .reset(reset),
        .mem_cmd(mem_cmd), .mem_row(mem_row), .mem_col(mem_col), .mem_bit(mem_bit),
        .mem_wdata(mem_wdata), .mem_clear(mem_clear),
        .mem_ready(mem_ready), .mem_done(mem_done),
        .rows_above(rows_above), .rows_mid(rows_mid), .rows_below(rows_below)
    );

endmodule

/* verif/life_tb.sv */
// APB testbench for the Life engine, runs every operation listed in verif/life_tests.txt
`timescale 1ns/1ps
`include "life_defs.svh"

module life_tb;

    localparam int    CLK_PERIOD      = 100;
    localparam int    CYCLES_PER_LINE = 4000;
    localparam string TEST_FILE       = "verif/life_tests.txt";

    logic                            clock;
    logic                            reset;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [`LIFE_APB_ADDR_BITS-1:0]  paddr;
    logic [31:0]                     pwdata;
    logic [31:0]                     prdata;
    logic                            pready;
    logic                            pslverr;

    // watchdog budget comes from the length of the data file
    int   line_count;
    logic counted;

    life_top UUT (
        .clock(clock), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #(CLK_PERIOD/2) clock = ~clock;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // one APB3 transfer, inputs change on the falling edge only
    task automatic apb_transfer(input logic write, input logic [`LIFE_APB_ADDR_BITS-1:0] addr,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic err);
        logic done;
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        // outputs settle well before the rising edge
        #(CLK_PERIOD/4);
        compare_value("pready in setup", 32'd0, {31'd0, pready});
        @(negedge clock);
        penable = 1'b1;
        done    = 1'b0;
        while (!done) begin
            #(CLK_PERIOD/4);
            if (pready) begin
                rdata = prdata;
                err   = pslverr;
                done  = 1'b1;
            end
            // transfer ends on the rising edge inside this wait
            @(negedge clock);
        end
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // read CTRL until the busy bit drops
    task automatic poll_idle();
        logic [31:0] status;
        logic        err;
        status = 32'h1;
        while (status[0]) begin
            apb_transfer(1'b0, `LIFE_REG_CTRL, 32'd0, status, err);
            compare_value("pslverr on status poll", 32'd0, {31'd0, err});
        end
    endtask

    task automatic run_operation(input logic [63:0] op,
                                 input logic [`LIFE_APB_ADDR_BITS-1:0] addr,
                                 input logic [31:0] data, input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        string       where;
        where = $sformatf("prdata at 0x%0h", addr);
        case (op)
            "W": begin
                apb_transfer(1'b1, addr, data, rdata, err);
                compare_value("pslverr", 32'd0, {31'd0, err});
            end
            "R": begin
                apb_transfer(1'b0, addr, data, rdata, err);
                compare_value("pslverr", 32'd0, {31'd0, err});
                compare_value(where, expected, rdata);
            end
            // accesses that must be refused
            "EW": begin
                apb_transfer(1'b1, addr, data, rdata, err);
                compare_value("pslverr", 32'd1, {31'd0, err});
            end
            "ER": begin
                apb_transfer(1'b0, addr, data, rdata, err);
                compare_value("pslverr", 32'd1, {31'd0, err});
            end
            "P": poll_idle();
            default: begin
                $display("unknown operation %0s in the test file", op);
                $display("TEST FAIL");
                $fatal(1, "bad test file");
            end
        endcase
    endtask

    task automatic open_test_file(output int fd);
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test file %s", TEST_FILE);
            $display("TEST FAIL");
            $fatal(1, "missing test file");
        end
    endtask

    task automatic count_lines();
        int               fd;
        int               code;
        logic [8*256-1:0] text;
        open_test_file(fd);
        line_count = 0;
        while (!$feof(fd)) begin
            code = $fgets(text, fd);
            if (code != 0)
                line_count++;
        end
        $fclose(fd);
        counted = 1'b1;
    endtask

    task automatic run_tests();
        int               fd;
        int               code;
        logic             more;
        logic [63:0]      op;
        logic [8*256-1:0] text;
        logic [31:0]      addr_val;
        logic [31:0]      data_val;
        logic [31:0]      expected_val;
        open_test_file(fd);
        more = 1'b1;
        while (more) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                more = 1'b0;
            end else if (op == "#") begin
                // skip the rest of a comment line
                code = $fgets(text, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h", addr_val, data_val, expected_val);
                if (code != 3) begin
                    $display("malformed operation line in the test file");
                    $display("TEST FAIL");
                    $fatal(1, "bad test file");
                end else begin
                    run_operation(op, addr_val[`LIFE_APB_ADDR_BITS-1:0], data_val, expected_val);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        counted     = 1'b0;
        count_lines();
        // reset over three rising edges
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        run_tests();
        $display("TEST PASS");
        $finish;
    end

    // watchdog
    initial begin
        wait (counted);
        repeat (line_count * CYCLES_PER_LINE) @(posedge clock);
        $display("the tests timed out after %0d clock cycles", line_count * CYCLES_PER_LINE);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

/* verif/life_tests.txt */
# columns: op addr data expected, all hex, unused fields 0; CELL data is row 19:16 col 11:8 value 0
# ops: W write, R read and compare, EW/ER write/read ending in pslverr, P poll CTRL until idle
# after reset the engine is idle and every row is dead
R 0 00000000 000
R 8 00000000 000
R 8 00010000 000
R 8 00020000 000
R 8 00030000 000
R 8 00040000 000
R 8 00050000 000
R 8 00060000 000
R 8 00070000 000
R 8 00080000 000
R 8 00090000 000
R 8 000a0000 000
R 8 000b0000 000
# single cells, both edge columns, then one removed
W 4 00020301 0
W 4 00020701 0
W 4 00020001 0
W 4 00020b01 0
R 8 00020000 889
W 4 00020300 0
R 8 00020000 881
R 8 00010000 000
R 8 00030000 000
W 0 00000002 0
R 8 00020000 000
# blinker in the middle and a block in the bottom right corner
W 4 00050401 0
W 4 00050501 0
W 4 00050601 0
W 4 000a0a01 0
W 4 000a0b01 0
W 4 000b0a01 0
W 4 000b0b01 0
R 8 00050000 070
R 8 000b0000 c00
W 0 00000101 0
P 0 00000000 0
R 0 00000000 100
R 8 00040000 020
R 8 00050000 020
R 8 00060000 020
R 8 000a0000 c00
R 8 000b0000 c00
W 0 00000101 0
P 0 00000000 0
R 0 00000000 200
R 8 00040000 000
R 8 00050000 070
R 8 00060000 000
R 8 00090000 000
R 8 000a0000 c00
R 8 000b0000 c00
# glider from the top left corner, four generations, refused accesses while busy
W 0 00000002 0
R 0 00000000 000
R 8 000a0000 000
W 4 00000101 0
W 4 00010201 0
W 4 00020001 0
W 4 00020101 0
W 4 00020201 0
R 8 00000000 002
R 8 00010000 004
R 8 00020000 007
W 0 00000401 0
R 0 00000000 001
EW 4 00050501 0
ER 8 00000000 0
P 0 00000000 0
R 0 00000000 400
R 8 00000000 000
R 8 00010000 004
R 8 00020000 008
R 8 00030000 00e
R 8 00040000 000
R 8 00050000 000
# zero generation start and unmapped offsets
W 0 00000001 0
R 0 00000000 400
EW c 00000000 0
ER 2 00000000 0
# clear leaves a dead grid and a zero count
W 0 00000002 0
R 0 00000000 000
R 8 00000000 000
R 8 00010000 000
R 8 00020000 000
R 8 00030000 000
R 8 00040000 000
R 8 00050000 000
R 8 00060000 000
R 8 00070000 000
R 8 00080000 000
R 8 00090000 000
R 8 000a0000 000
R 8 000b0000 000

/* build.f */
+incdir+verilog
verilog/life_mem_pkg.sv
verilog/life_regs_pkg.sv
verilog/row_bank_mem.sv
verilog/life_row_step.sv
verilog/life_sequencer.sv
verilog/life_apb_regs.sv
verilog/life_top.sv
verif/life_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the Life engine testbench with Verilator, run it, and pass only if TEST PASS is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module life_tb -f build.f \
    -Mdir obj_dir -o life_sim \
    && ./obj_dir/life_sim | tee /dev/stderr | grep -x "TEST PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
